// File: rtl/cache_pkg.sv
package cache_pkg;

	// Geometry of the four-way cache
	localparam int ways = 4;
	localparam int sets = 64;
	localparam int index_bits = 6; // Address bits 9 to 4
	localparam int offset_bits = 4; // 16-byte lines
	localparam int words_per_line = 4;
	localparam int tag_bits = 22; // Address bits 31 to 10

	typedef logic [tag_bits-1:0] tag_t;

	// Word 0 sits in the low 32 bits
	typedef logic [words_per_line-1:0][31:0] line_t;

	typedef logic [ways-1:0] way_sel_t; // One-hot

endpackage

// File: rtl/wb_pkg.sv
package wb_pkg;

	// Wishbone classic, 32-bit
	localparam int adr_bits = 32;
	localparam int dat_bits = 32;

	typedef logic [dat_bits-1:0] word_t; // Bus word and instruction word

endpackage

// File: rtl/cache_if.sv
// Decode to result and refill, one cycle after the lookup
interface lookup_if;
	logic hit;
	cache_pkg::way_sel_t hit_way;
	cache_pkg::line_t way_line [cache_pkg::ways];
	logic [$clog2(cache_pkg::words_per_line)-1:0] word_offset;
	logic miss;
	wb_pkg::word_t miss_addr;

	modport decode (output hit, hit_way, way_line, word_offset, miss, miss_addr);
	modport result (input hit, hit_way, way_line, word_offset, miss);
	modport refill (input miss, miss_addr);
endinterface

// Refill back to decode (array write) and result (response word)
interface refill_if;
	logic fill_en;
	cache_pkg::way_sel_t fill_way;
	logic [cache_pkg::index_bits-1:0] fill_index;
	cache_pkg::tag_t fill_tag;
	cache_pkg::line_t fill_line;
	logic done;
	wb_pkg::word_t fill_word;

	modport refill (output fill_en, fill_way, fill_index, fill_tag, fill_line, done, fill_word);
	modport decode (input fill_en, fill_way, fill_index, fill_tag, fill_line, done);
	modport result (input done, fill_word);
endinterface

// File: rtl/cache_array.sv
// One entry per set, registered read, one write port
module cache_array #(
	parameter type entry_t = logic [31:0]
) (
	input logic clk,

	input logic rd_en,
	input logic [cache_pkg::index_bits-1:0] rd_index,
	output entry_t rd_data,

	input logic wr_en,
	input logic [cache_pkg::index_bits-1:0] wr_index,
	input entry_t wr_data
);

	entry_t mem [cache_pkg::sets];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_index] <= wr_data;
		end
	end

	// Output holds while rd_en is low
	always_ff @(posedge clk) begin
		if (rd_en) begin
			if (wr_en && (wr_index == rd_index)) begin
				rd_data <= wr_data; // Fill in the same cycle wins
			end else begin
				rd_data <= mem[rd_index];
			end
		end
	end

endmodule

// File: rtl/icache_decode.sv
module icache_decode (
	input logic clk,
	input logic rst,

	input logic fetch_valid,
	input wb_pkg::word_t fetch_addr,
	output logic fetch_ready,

	lookup_if.decode lookup,
	refill_if.decode refill
);

	logic accept;
	logic stall;
	logic busy;
	logic [cache_pkg::index_bits-1:0] fetch_index;

	logic [cache_pkg::ways-1:0][cache_pkg::sets-1:0] valid_bits;
	cache_pkg::tag_t rd_tag [cache_pkg::ways];
	cache_pkg::line_t rd_line [cache_pkg::ways];

	// Lookup stage
	logic req_valid;
	wb_pkg::word_t req_addr;
	cache_pkg::way_sel_t req_vld;
	cache_pkg::tag_t req_tag;
	logic [cache_pkg::index_bits-1:0] req_index;

	cache_pkg::way_sel_t fill_hit;
	cache_pkg::way_sel_t way_match;
	cache_pkg::line_t cur_line [cache_pkg::ways];

	// Result stage
	logic hit_q;
	logic miss_q;
	cache_pkg::way_sel_t hit_way_q;
	cache_pkg::line_t line_q [cache_pkg::ways];
	logic [$clog2(cache_pkg::words_per_line)-1:0] offset_q;
	wb_pkg::word_t miss_addr_q;

	assign fetch_index = fetch_addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
	assign req_tag = req_addr[wb_pkg::adr_bits-1 -: cache_pkg::tag_bits];
	assign req_index = req_addr[cache_pkg::offset_bits +: cache_pkg::index_bits];

	// Held while a miss waits for its line
	assign stall = miss_q || (busy && !refill.done);
	assign fetch_ready = !stall;
	assign accept = fetch_valid && fetch_ready;

	for (genvar w = 0; w < cache_pkg::ways; w++) begin : g_way
		cache_array #(.entry_t(cache_pkg::tag_t)) tag_array (
			.clk(clk),
			.rd_en(accept),
			.rd_index(fetch_index),
			.rd_data(rd_tag[w]),
			.wr_en(refill.fill_en && refill.fill_way[w]),
			.wr_index(refill.fill_index),
			.wr_data(refill.fill_tag)
		);

		cache_array #(.entry_t(cache_pkg::line_t)) line_array (
			.clk(clk),
			.rd_en(accept),
			.rd_index(fetch_index),
			.rd_data(rd_line[w]),
			.wr_en(refill.fill_en && refill.fill_way[w]),
			.wr_index(refill.fill_index),
			.wr_data(refill.fill_line)
		);
	end

	// A fill during lookup overrides the stale way
	always_comb begin
		for (int w = 0; w < cache_pkg::ways; w++) begin
			fill_hit[w] = refill.fill_en && refill.fill_way[w] && (refill.fill_index == req_index);
			if (fill_hit[w]) begin
				way_match[w] = (refill.fill_tag == req_tag);
				cur_line[w] = refill.fill_line;
			end else begin
				way_match[w] = req_vld[w] && (rd_tag[w] == req_tag);
				cur_line[w] = rd_line[w];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
		end else if (refill.fill_en) begin
			for (int w = 0; w < cache_pkg::ways; w++) begin
				if (refill.fill_way[w]) valid_bits[w][refill.fill_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			req_valid <= 1'b0;
			hit_q <= 1'b0;
			miss_q <= 1'b0;
			hit_way_q <= '0;
			busy <= 1'b0;
		end else begin
			if (!stall) begin
				req_valid <= accept;
				hit_q <= req_valid && (|way_match);
				miss_q <= req_valid && !(|way_match);
				hit_way_q <= req_valid ? way_match : '0;
			end else begin
				hit_q <= 1'b0;
				miss_q <= 1'b0; // Miss shows for one cycle only
				hit_way_q <= '0;
			end
			if (miss_q) busy <= 1'b1;
			else if (refill.done) busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= fetch_addr;
			for (int w = 0; w < cache_pkg::ways; w++) begin
				req_vld[w] <= valid_bits[w][fetch_index] ||
					(refill.fill_en && refill.fill_way[w] && (refill.fill_index == fetch_index));
			end
		end
		if (!stall) begin
			line_q <= cur_line;
			offset_q <= req_addr[cache_pkg::offset_bits-1:2];
			miss_addr_q <= req_addr;
		end
	end

	assign lookup.hit = hit_q;
	assign lookup.miss = miss_q;
	assign lookup.hit_way = hit_way_q;
	assign lookup.way_line = line_q;
	assign lookup.word_offset = offset_q;
	assign lookup.miss_addr = miss_addr_q;

	// Two ways of one set never hold the same tag
	a_hit_way_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way_q));

endmodule

// File: rtl/icache_refill.sv
module icache_refill (
	input logic clk,
	input logic rst,

	lookup_if.refill lookup,
	refill_if.refill refill,

	output logic wb_cyc,
	output logic wb_stb,
	output wb_pkg::word_t wb_adr,
	input wb_pkg::word_t wb_dat_i,
	input logic wb_ack
);

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_fill
	} state_t;

	state_t state;
	logic [$clog2(cache_pkg::words_per_line)-1:0] beat;
	logic last_beat;
	cache_pkg::way_sel_t victim;
	cache_pkg::way_sel_t fill_way_q;
	wb_pkg::word_t miss_addr_q;
	cache_pkg::line_t line_buf;

	assign last_beat = (beat == $bits(beat)'(cache_pkg::words_per_line - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			beat <= '0;
			victim <= cache_pkg::way_sel_t'(1); // Way 0 first
		end else begin
			case (state)
				st_idle: begin
					if (lookup.miss) begin
						state <= st_read;
						beat <= '0;
						victim <= {victim[cache_pkg::ways-2:0], victim[cache_pkg::ways-1]};
					end
				end
				st_read: begin
					if (wb_ack) begin
						beat <= beat + 1'b1;
						if (last_beat) state <= st_fill;
					end
				end
				st_fill: state <= st_idle; // Line written this cycle
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && lookup.miss) begin
			miss_addr_q <= lookup.miss_addr;
			fill_way_q <= victim;
		end
		if (state == st_read && wb_ack) begin
			line_buf[beat] <= wb_dat_i;
		end
	end

	// Line-aligned, word 0 to word 3
	assign wb_cyc = (state == st_read);
	assign wb_stb = (state == st_read);
	assign wb_adr = {miss_addr_q[wb_pkg::adr_bits-1:cache_pkg::offset_bits], beat, 2'b00};

	assign refill.fill_en = (state == st_fill);
	assign refill.done = (state == st_fill);
	assign refill.fill_way = fill_way_q;
	assign refill.fill_index = miss_addr_q[cache_pkg::offset_bits +: cache_pkg::index_bits];
	assign refill.fill_tag = miss_addr_q[wb_pkg::adr_bits-1 -: cache_pkg::tag_bits];
	assign refill.fill_line = line_buf;
	assign refill.fill_word = line_buf[miss_addr_q[cache_pkg::offset_bits-1:2]];

	// Classic cycle holds stb, cyc and adr until the slave acks
	a_stb_held: assert property (@(posedge clk) disable iff (rst)
		(wb_stb && !wb_ack) |=> (wb_stb && wb_cyc && $stable(wb_adr)));

	a_victim_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(victim));

endmodule

// File: rtl/icache_result.sv
module icache_result (
	input logic clk,
	input logic rst,
	input logic flush,

	lookup_if.result lookup,
	refill_if.result refill,

	output logic resp_valid,
	output wb_pkg::word_t resp_inst
);

	cache_pkg::line_t hit_line;
	logic flush_q; // Cancels what leaves lookup next
	logic pending;
	logic cancel_q;
	logic held_flush;
	logic stall_flush;

	always_comb begin
		hit_line = '0;
		for (int w = 0; w < cache_pkg::ways; w++) begin
			if (lookup.hit_way[w]) hit_line = lookup.way_line[w];
		end
	end

	// Hit and done never share a cycle
	assign resp_inst = refill.done ? refill.fill_word : hit_line[lookup.word_offset];
	assign resp_valid = (lookup.hit && !flush && !flush_q) ||
		(refill.done && !flush && !cancel_q);

	// Flush while a refill is outstanding
	assign stall_flush = flush && (pending || lookup.miss);

	always_ff @(posedge clk) begin
		if (rst) begin
			flush_q <= 1'b0;
			pending <= 1'b0;
			cancel_q <= 1'b0;
			held_flush <= 1'b0;
		end else begin
			// Request held in lookup during the refill leaves right after done
			flush_q <= flush || (refill.done && held_flush);
			if (lookup.miss) pending <= 1'b1;
			else if (refill.done) pending <= 1'b0;
			if (refill.done) begin
				cancel_q <= 1'b0;
				held_flush <= 1'b0;
			end else begin
				if (stall_flush || (lookup.miss && flush_q)) cancel_q <= 1'b1;
				if (stall_flush) held_flush <= 1'b1;
			end
		end
	end

endmodule

// File: rtl/icache_top.sv
module icache_top (
	input logic clk,
	input logic rst,

	input logic fetch_valid,
	input wb_pkg::word_t fetch_addr,
	output logic fetch_ready,
	input logic flush,
	output logic resp_valid,
	output wb_pkg::word_t resp_inst,

	output logic wb_cyc,
	output logic wb_stb,
	output wb_pkg::word_t wb_adr,
	input wb_pkg::word_t wb_dat_i,
	input logic wb_ack
);

	lookup_if lookup ();
	refill_if refill ();

	// Tag lookup and arrays
	icache_decode icache_decode_inst (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready),
		.lookup(lookup.decode),
		.refill(refill.decode)
	);

	// Miss handling over Wishbone
	icache_refill icache_refill_inst (
		.clk(clk),
		.rst(rst),
		.lookup(lookup.refill),
		.refill(refill.refill),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack)
	);

	icache_result icache_result_inst (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.lookup(lookup.result),
		.refill(refill.result),
		.resp_valid(resp_valid),
		.resp_inst(resp_inst)
	);

endmodule

// File: test/icache_tb_mem.sv
// Wishbone classic slave, data follows the address
module icache_tb_mem (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input wb_pkg::word_t adr,
	output wb_pkg::word_t dat,
	output logic ack
);

	logic [31:0] lfsr_state;
	int wait_cnt;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Two bits for a delay of zero to three cycles
	task automatic draw_delay();
		lfsr_state = lfsr_step(lfsr_state);
		wait_cnt = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
		wait_cnt = wait_cnt + 2 * lfsr_state[0];
	endtask

	initial begin
		lfsr_state = 32'h7f3e;
		draw_delay();
	end

	always @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			dat <= '0;
		end else if (ack) begin
			ack <= 1'b0; // One beat per ack
			draw_delay();
		end else if (cyc && stb) begin
			if (wait_cnt == 0) begin
				ack <= 1'b1;
				dat <= {adr[31:2], 2'b00} ^ 32'hc0de0000;
			end else begin
				wait_cnt = wait_cnt - 1;
			end
		end
	end

endmodule

// File: test/icache_tb.sv
module icache_tb;

	typedef struct {
		string name;
		logic [31:0] addr;
		bit flush;
		bit hit;
	} entry_t;

	localparam int num_tests = 18;
	localparam int worst_miss = 32; // Four beats of up to five cycles, plus lookup and fill

	logic clk;
	logic rst;
	logic fetch_valid;
	wb_pkg::word_t fetch_addr;
	logic fetch_ready;
	logic flush;
	logic resp_valid;
	wb_pkg::word_t resp_inst;
	logic wb_cyc;
	logic wb_stb;
	wb_pkg::word_t wb_adr;
	wb_pkg::word_t wb_dat_i;
	logic wb_ack;

	entry_t tests [num_tests];
	int ack_count;
	logic [31:0] line_addr; // Address whose line goes over the bus

	// Reference tag store and victim rotation
	logic [cache_pkg::tag_bits-1:0] model_tag [cache_pkg::sets][cache_pkg::ways];
	bit model_valid [cache_pkg::sets][cache_pkg::ways];
	int model_victim;

	icache_top icache_top_inst (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready),
		.flush(flush),
		.resp_valid(resp_valid),
		.resp_inst(resp_inst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack)
	);

	icache_tb_mem mem_inst (
		.clk(clk),
		.rst(rst),
		.cyc(wb_cyc),
		.stb(wb_stb),
		.adr(wb_adr),
		.dat(wb_dat_i),
		.ack(wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!rst) check("bus stb", wb_cyc, wb_stb); // Raised and dropped together
		if (wb_cyc && wb_stb && wb_ack) begin
			// Line-aligned reads in ascending word order
			check("bus adr", (line_addr & 32'hfffffff0) + 4 * ack_count, wb_adr);
			ack_count <= ack_count + 1;
		end
	end

	initial begin
		#((num_tests * worst_miss + 40) * 8);
		$display("Timeout: the cache stopped answering");
		$display("ERRORS FOUND");
		$fatal(1);
	end

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	function automatic bit model_lookup(input logic [31:0] addr);
		int idx;
		logic [cache_pkg::tag_bits-1:0] tag;
		idx = addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
		tag = addr[31 -: cache_pkg::tag_bits];
		for (int w = 0; w < cache_pkg::ways; w++) begin
			if (model_valid[idx][w] && model_tag[idx][w] == tag) return 1'b1;
		end
		model_valid[idx][model_victim] = 1'b1; // Miss fills the victim even when flushed
		model_tag[idx][model_victim] = tag;
		model_victim = (model_victim + 1) % cache_pkg::ways;
		return 1'b0;
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'hc0de0000;
	endfunction

	task automatic run_entry(input entry_t t);
		bit hit;
		hit = model_lookup(t.addr);
		check({t.name, " model"}, t.hit, hit);
		@(posedge clk);
		#1;
		check({t.name, " idle resp"}, 0, resp_valid); // Previous response lasts one cycle
		ack_count = 0;
		line_addr = t.addr;
		fetch_valid = 1'b1;
		fetch_addr = t.addr;
		@(posedge clk); // Accepted here
		#1;
		fetch_valid = 1'b0;
		flush = t.flush;
		check({t.name, " early resp"}, 0, resp_valid);
		@(posedge clk);
		#1;
		flush = 1'b0;
		#1;
		if (!hit) begin
			check({t.name, " ready low"}, 0, fetch_ready);
			while (!fetch_ready) begin
				@(posedge clk);
				#2;
			end
		end
		check({t.name, " resp_valid"}, !t.flush, resp_valid);
		if (!t.flush) check({t.name, " resp_inst"}, mem_word(t.addr), resp_inst);
		check({t.name, " acks"}, hit ? 0 : 4, ack_count);
	endtask

	initial begin
		model_victim = 0;
		foreach (model_valid[s, w]) model_valid[s][w] = 1'b0;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		flush = 1'b0;
		ack_count = 0;
		line_addr = '0;
		rst = 1'b1;
		tests[0] = '{"cold_off0", 32'h00001010, 0, 0};
		tests[1] = '{"cold_off1", 32'h00001024, 0, 0};
		tests[2] = '{"cold_off2", 32'h00001038, 0, 0};
		tests[3] = '{"cold_off3", 32'h0000104c, 0, 0};
		tests[4] = '{"repeat_hit_a", 32'h00001014, 0, 1};
		tests[5] = '{"repeat_hit_b", 32'h00001018, 0, 1};
		tests[6] = '{"set7_line1", 32'h00000470, 0, 0};
		tests[7] = '{"set7_line2", 32'h00000874, 0, 0};
		tests[8] = '{"set7_line3", 32'h00000c78, 0, 0};
		tests[9] = '{"set7_line4", 32'h0000107c, 0, 0};
		tests[10] = '{"set7_line5", 32'h00001470, 0, 0};
		tests[11] = '{"evicted_miss", 32'h00000474, 0, 0};
		tests[12] = '{"third_hit", 32'h00000c70, 0, 1};
		tests[13] = '{"flushed_hit", 32'h00001010, 1, 1};
		tests[14] = '{"flushed_miss", 32'h00002050, 1, 0};
		tests[15] = '{"after_flush_hit", 32'h00002054, 0, 1};
		tests[16] = '{"wait_miss_a", 32'h80000108, 0, 0};
		tests[17] = '{"wait_miss_b", 32'hfffffff4, 0, 0};
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		#1;
		check("reset ready", 1, fetch_ready);
		check("reset cyc", 0, wb_cyc);
		check("reset resp", 0, resp_valid);
		for (int i = 0; i < num_tests; i++) run_entry(tests[i]);

		// Back-to-back hits give responses on consecutive cycles
		@(posedge clk);
		#1;
		ack_count = 0;
		fetch_valid = 1'b1;
		fetch_addr = 32'h00001024;
		@(posedge clk);
		#1;
		fetch_addr = 32'h00001038;
		@(posedge clk);
		#1;
		fetch_valid = 1'b0;
		#1;
		check("b2b first valid", 1, resp_valid);
		check("b2b first inst", mem_word(32'h00001024), resp_inst);
		@(posedge clk);
		#2;
		check("b2b second valid", 1, resp_valid);
		check("b2b second inst", mem_word(32'h00001038), resp_inst);
		check("b2b acks", 0, ack_count);

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: icache_top.f
rtl/cache_pkg.sv
rtl/wb_pkg.sv
rtl/cache_if.sv
rtl/cache_array.sv
rtl/icache_decode.sv
rtl/icache_refill.sv
rtl/icache_result.sv
rtl/icache_top.sv
test/icache_tb_mem.sv
test/icache_tb.sv
